// ==== board_settings.svh ====
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// random generator width
`define LFSR_WIDTH 8

// scancode queue entries, power of two
`define KBD_QUEUE_DEPTH 8

// flip-flops on each PS/2 line
`define PS2_SYNC_STAGES 2

`endif

// ==== board_pkg.sv ====
`default_nettype none

package board_pkg;

    typedef enum logic [2:0] {
        add         = 3'b000,
        sub         = 3'b001,
        not_a       = 3'b010,
        and_op      = 3'b011,
        or_op       = 3'b100,
        xor_op      = 3'b101,
        less_signed = 3'b110,
        equal       = 3'b111
    } alu_op_e;

    // active low, bit 7 is the decimal point, bits 6..0 are g..a
    typedef logic [7:0] seg_t;

    typedef logic [7:0] scancode_t;

    // set-2 make codes for a..z and 0..9
    function automatic logic [7:0] scan_to_ascii(scancode_t code);
        case (code)
            8'h1c: return 8'h61;
            8'h32: return 8'h62;
            8'h21: return 8'h63;
            8'h23: return 8'h64;
            8'h24: return 8'h65;
            8'h2b: return 8'h66;
            8'h34: return 8'h67;
            8'h33: return 8'h68;
            8'h43: return 8'h69;
            8'h3b: return 8'h6a;
            8'h42: return 8'h6b;
            8'h4b: return 8'h6c;
            8'h3a: return 8'h6d;
            8'h31: return 8'h6e;
            8'h44: return 8'h6f;
            8'h4d: return 8'h70;
            8'h15: return 8'h71;
            8'h2d: return 8'h72;
            8'h1b: return 8'h73;
            8'h2c: return 8'h74;
            8'h3c: return 8'h75;
            8'h2a: return 8'h76;
            8'h1d: return 8'h77;
            8'h22: return 8'h78;
            8'h35: return 8'h79;
            8'h1a: return 8'h7a;
            8'h45: return 8'h30;
            8'h16: return 8'h31;
            8'h1e: return 8'h32;
            8'h26: return 8'h33;
            8'h25: return 8'h34;
            8'h2e: return 8'h35;
            8'h36: return 8'h36;
            8'h3d: return 8'h37;
            8'h3e: return 8'h38;
            8'h46: return 8'h39;
            default: return 8'h00;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  logic               [3:0] a,
    input  logic               [3:0] b,
    input  board_pkg::alu_op_e       op,
    output logic               [3:0] result,
    output logic                     zero,
    output logic                     overflow,
    output logic                     carry
);
    import board_pkg::*;

    logic [4:0] sum;
    logic [4:0] diff;

    assign sum  = {1'b0, a} + {1'b0, b};
    // a plus not b plus one, carry out is the inverted borrow
    assign diff = {1'b0, a} + {1'b0, ~b} + 5'd1;

    always_comb begin
        result   = 4'd0;
        overflow = 1'b0;
        carry    = 1'b0;
        case (op)
            add: begin
                result   = sum[3:0];
                carry    = sum[4];
                overflow = (a[3] == b[3]) && (sum[3] != a[3]);
            end
            sub: begin
                result   = diff[3:0];
                carry    = diff[4];
                overflow = (a[3] != b[3]) && (diff[3] != a[3]);
            end
            not_a: begin
                result = ~a;
            end
            and_op: begin
                result = a & b;
            end
            or_op: begin
                result = a | b;
            end
            xor_op: begin
                result = a ^ b;
            end
            less_signed: begin
                result = {3'b000, $signed(a) < $signed(b)};
            end
            equal: begin
                result = {3'b000, a == b};
            end
        endcase
    end

    assign zero = (result == 4'd0);

endmodule

`default_nettype wire

// ==== lfsr_random.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "board_settings.svh"

module lfsr_random (
    input  logic                   btn,
    input  logic                   rst_n,
    input  logic                   step,
    output logic [`LFSR_WIDTH-1:0] value
);

    localparam logic [`LFSR_WIDTH-1:0] seed = 1;

    logic feedback;

    // taps at bits 4, 3, 2 and 0, shifted in at the top
    assign feedback = value[4] ^ value[3] ^ value[2] ^ value[0];

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            value <= seed;
        end else if (step) begin
            // recover from the all-zero lockup state
            if (value == '0) begin
                value <= seed;
            end else begin
                value <= {feedback, value[`LFSR_WIDTH-1:1]};
            end
        end
    end

    // a nonzero state never steps into zero
    a_never_zero: assert property (
        @(posedge btn) disable iff (!rst_n)
        value != '0
    );

endmodule

`default_nettype wire

// ==== ps2_receiver.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "board_settings.svh"

module ps2_receiver (
    input  logic                 btn,
    input  logic                 rst_n,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    output board_pkg::scancode_t frame_code,
    output logic                 frame_valid
);

    localparam int sync_len = `PS2_SYNC_STAGES;

    logic [sync_len-1:0] clk_sync;
    logic [sync_len-1:0] data_sync;
    logic                clk_prev;
    logic                ps2_fall;
    logic [3:0]          bit_cnt;
    logic [10:0]         frame_shift;
    logic                frame_done;
    logic                frame_ok;

    // both lines idle high
    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[sync_len-2:0], ps2_clk};
            data_sync <= {data_sync[sync_len-2:0], ps2_data};
            clk_prev  <= clk_sync[sync_len-1];
        end
    end

    assign ps2_fall = clk_prev & ~clk_sync[sync_len-1];

    // counts start, data, parity, stop
    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (ps2_fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // lsb first, so the start bit ends up in bit 0
    always_ff @(posedge btn) begin
        if (ps2_fall) begin
            frame_shift <= {data_sync[sync_len-1], frame_shift[10:1]};
        end
    end

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame_shift[0] & frame_shift[10] & (^frame_shift[9:1]);

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_done & frame_ok;
        end
    end

    assign frame_code = frame_shift[8:1];

    a_single_strobe: assert property (
        @(posedge btn) disable iff (!rst_n)
        frame_valid |=> !frame_valid
    );

endmodule

`default_nettype wire

// ==== scancode_queue.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "board_settings.svh"

module scancode_queue (
    input  logic                 btn,
    input  logic                 rst_n,
    input  logic                 push,
    input  board_pkg::scancode_t push_code,
    input  logic                 pop_switch,
    output board_pkg::scancode_t head,
    output logic                 ready,
    output logic                 overflow
);
    import board_pkg::*;

    localparam int depth = `KBD_QUEUE_DEPTH;
    localparam int ptr_w = $clog2(depth);

    scancode_t        mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             pop_last;
    logic             pop_req;
    logic             full;
    logic             do_write;
    logic             do_read;

    assign full     = (count == (ptr_w + 1)'(depth));
    assign ready    = (count != '0);
    assign do_write = push & ~full;
    assign do_read  = pop_req & ready;

    // rising edge of the pop switch, acted on one cycle later
    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            pop_last <= 1'b0;
            pop_req  <= 1'b0;
        end else begin
            pop_last <= pop_switch;
            pop_req  <= pop_switch & ~pop_last;
        end
    end

    always_ff @(posedge btn or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky, frames arriving while full are lost
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge btn) begin
        if (do_write) begin
            mem[wr_ptr] <= push_code;
        end
    end

    // empty queue reads as zero
    assign head = ready ? mem[rd_ptr] : '0;

    a_count_bound: assert property (
        @(posedge btn) disable iff (!rst_n)
        count <= (ptr_w + 1)'(depth)
    );

    a_no_underflow: assert property (
        @(posedge btn) disable iff (!rst_n)
        (count == '0) |=> (count <= 1)
    );

endmodule

`default_nettype wire

// ==== hex_to_seg.sv ====
`default_nettype none
`timescale 1ns/100ps

module hex_to_seg (
    input  logic [3:0]      digit,
    output board_pkg::seg_t pattern
);

    // active low, decimal point kept dark
    always_comb begin
        case (digit)
            4'h0: pattern = 8'hc0;
            4'h1: pattern = 8'hf9;
            4'h2: pattern = 8'ha4;
            4'h3: pattern = 8'hb0;
            4'h4: pattern = 8'h99;
            4'h5: pattern = 8'h92;
            4'h6: pattern = 8'h82;
            4'h7: pattern = 8'hf8;
            4'h8: pattern = 8'h80;
            4'h9: pattern = 8'h90;
            4'ha: pattern = 8'h88;
            4'hb: pattern = 8'h83;
            4'hc: pattern = 8'hc6;
            4'hd: pattern = 8'ha1;
            4'he: pattern = 8'h86;
            4'hf: pattern = 8'h8e;
        endcase
    end

endmodule

`default_nettype wire

// ==== board_top.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "board_settings.svh"

module board_top (
    input  logic            btn,
    input  logic            rst_n,
    input  logic [15:0]     sw,
    input  logic            ps2_clk,
    input  logic            ps2_data,
    output logic [15:0]     ledr,
    output board_pkg::seg_t seg0,
    output board_pkg::seg_t seg1,
    output board_pkg::seg_t seg2,
    output board_pkg::seg_t seg3,
    output board_pkg::seg_t seg4,
    output board_pkg::seg_t seg5,
    output board_pkg::seg_t seg6,
    output board_pkg::seg_t seg7
);
    import board_pkg::*;

    // only segment g lit
    localparam seg_t seg_minus = 8'hbf;
    localparam seg_t seg_blank = 8'hff;

    alu_op_e                alu_op;
    logic [3:0]             alu_result;
    logic                   alu_zero;
    logic                   alu_overflow;
    logic                   alu_carry;
    logic [`LFSR_WIDTH-1:0] rnd_value;
    scancode_t              frame_code;
    logic                   frame_valid;
    scancode_t              head_code;
    logic                   kbd_ready;
    logic                   kbd_overflow;
    logic [7:0]             ascii_code;

    assign alu_op = alu_op_e'(sw[10:8]);

    alu alu_inst (
        .a        (sw[3:0]),
        .b        (sw[7:4]),
        .op       (alu_op),
        .result   (alu_result),
        .zero     (alu_zero),
        .overflow (alu_overflow),
        .carry    (alu_carry)
    );

    lfsr_random lfsr_random_inst (
        .btn   (btn),
        .rst_n (rst_n),
        .step  (sw[15]),
        .value (rnd_value)
    );

    ps2_receiver ps2_receiver_inst (
        .btn         (btn),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .frame_code  (frame_code),
        .frame_valid (frame_valid)
    );

    // pop on sw[11] going high
    scancode_queue scancode_queue_inst (
        .btn        (btn),
        .rst_n      (rst_n),
        .push       (frame_valid),
        .push_code  (frame_code),
        .pop_switch (sw[11]),
        .head       (head_code),
        .ready      (kbd_ready),
        .overflow   (kbd_overflow)
    );

    assign ascii_code = scan_to_ascii(head_code);

    assign ledr = {7'd0, kbd_overflow, kbd_ready, alu_carry, alu_overflow, alu_zero, alu_result};

    hex_to_seg seg0_inst (.digit(head_code[3:0]), .pattern(seg0));
    hex_to_seg seg1_inst (.digit(head_code[7:4]), .pattern(seg1));
    hex_to_seg seg2_inst (.digit(ascii_code[3:0]), .pattern(seg2));
    hex_to_seg seg3_inst (.digit(ascii_code[7:4]), .pattern(seg3));
    hex_to_seg seg4_inst (.digit(rnd_value[3:0]), .pattern(seg4));
    hex_to_seg seg5_inst (.digit(rnd_value[7:4]), .pattern(seg5));
    hex_to_seg seg6_inst (.digit(alu_result), .pattern(seg6));

    // sign of the ALU result read as two's complement
    assign seg7 = alu_result[3] ? seg_minus : seg_blank;

endmodule

`default_nettype wire

// ==== tb_board_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_board_top;
    import board_pkg::*;

    localparam int half_period  = 8;
    localparam int frame_cycles = 11 * 2 * half_period + 16;
    localparam int pop_cycles   = 5;
    localparam int lfsr_steps   = 37;
    localparam int test_cycles  = 12 + 40 + lfsr_steps + 12 + 13 * frame_cycles
                                  + 12 * pop_cycles + 20;
    localparam int watchdog_ns  = test_cycles * 20 * 3 / 2;

    logic        btn;
    logic        rst_n;
    logic [15:0] sw;
    logic        ps2_clk;
    logic        ps2_data;
    logic [15:0] ledr;
    seg_t        seg0;
    seg_t        seg1;
    seg_t        seg2;
    seg_t        seg3;
    seg_t        seg4;
    seg_t        seg5;
    seg_t        seg6;
    seg_t        seg7;

    integer      seed;
    logic [7:0]  rnd_model;

    board_top board_top_inst (
        .btn      (btn),
        .rst_n    (rst_n),
        .sw       (sw),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .ledr     (ledr),
        .seg0     (seg0),
        .seg1     (seg1),
        .seg2     (seg2),
        .seg3     (seg3),
        .seg4     (seg4),
        .seg5     (seg5),
        .seg6     (seg6),
        .seg7     (seg7)
    );

    always #10 btn = ~btn;

    function automatic seg_t seg_font(logic [3:0] digit);
        seg_t font [16] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
                            8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};
        return font[digit];
    endfunction

    // only the codes the tests send
    function automatic logic [7:0] ascii_of(logic [7:0] code);
        case (code)
            8'h1c: return 8'h61;
            8'h32: return 8'h62;
            8'h45: return 8'h30;
            8'h16: return 8'h31;
            8'h1e: return 8'h32;
            8'h26: return 8'h33;
            8'h25: return 8'h34;
            8'h2e: return 8'h35;
            8'h36: return 8'h36;
            8'h3d: return 8'h37;
            8'h3e: return 8'h38;
            8'h46: return 8'h39;
            default: return 8'h00;
        endcase
    endfunction

    function automatic logic [7:0] lfsr_next(logic [7:0] v);
        if (v == 8'd0) begin
            return 8'd1;
        end
        return {v[4] ^ v[3] ^ v[2] ^ v[0], v[7:1]};
    endfunction

    // returns {carry, overflow, zero, result} in ledr order
    function automatic logic [6:0] alu_model(logic [3:0] a, logic [3:0] b, alu_op_e op);
        int         sa;
        int         sb;
        int         s;
        logic [3:0] r;
        logic       c;
        logic       v;
        sa = a[3] ? int'(a) - 16 : int'(a);
        sb = b[3] ? int'(b) - 16 : int'(b);
        c = 1'b0;
        v = 1'b0;
        r = 4'd0;
        case (op)
            add: begin
                s = int'(a) + int'(b);
                r = s[3:0];
                c = (s > 15);
                v = (sa + sb > 7) || (sa + sb < -8);
            end
            sub: begin
                s = int'(a) - int'(b);
                r = s[3:0];
                c = (a >= b);
                v = (sa - sb > 7) || (sa - sb < -8);
            end
            not_a:       r = ~a;
            and_op:      r = a & b;
            or_op:       r = a | b;
            xor_op:      r = a ^ b;
            less_signed: r = (sa < sb) ? 4'd1 : 4'd0;
            equal:       r = (a == b) ? 4'd1 : 4'd0;
        endcase
        return {c, v, (r == 4'd0), r};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            repeat (half_period) @(negedge btn);
            ps2_clk = 1'b0;
            repeat (half_period) @(negedge btn);
            ps2_clk = 1'b1;
        end
        repeat (16) @(negedge btn);
    endtask

    task automatic wait_ready(input int max_cycles);
        int n;
        n = 0;
        while (ledr[7] !== 1'b1 && n < max_cycles) begin
            @(negedge btn);
            n++;
        end
        if (ledr[7] !== 1'b1) begin
            $display("keyboard ready did not rise within %0d cycles", max_cycles);
            $display("Verification failed");
            $fatal(1, "ready timeout");
        end
    endtask

    task automatic pop_key();
        sw[11] = 1'b1;
        repeat (3) @(negedge btn);
        sw[11] = 1'b0;
        repeat (pop_cycles - 3) @(negedge btn);
    endtask

    task automatic show_head(input logic [7:0] code);
        logic [7:0] ascii;
        ascii = ascii_of(code);
        check_value("seg0", seg_font(code[3:0]), seg0);
        check_value("seg1", seg_font(code[7:4]), seg1);
        check_value("seg2", seg_font(ascii[3:0]), seg2);
        check_value("seg3", seg_font(ascii[7:4]), seg3);
    endtask

    task automatic test_reset_state();
        check_value("ledr[8:7]", 2'b00, ledr[8:7]);
        check_value("seg4", seg_font(4'h1), seg4);
        check_value("seg5", seg_font(4'h0), seg5);
        show_head(8'h00);
    endtask

    task automatic test_alu();
        logic [31:0] r;
        logic [6:0]  exp_flags;
        alu_op_e     op;
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            op = alu_op_e'(i % 8);
            sw[3:0] = r[3:0];
            sw[7:4] = r[7:4];
            sw[10:8] = op;
            @(negedge btn);
            exp_flags = alu_model(r[3:0], r[7:4], op);
            check_value("alu result", exp_flags[3:0], ledr[3:0]);
            check_value("alu zero", exp_flags[4], ledr[4]);
            check_value("alu overflow", exp_flags[5], ledr[5]);
            check_value("alu carry", exp_flags[6], ledr[6]);
            check_value("seg6", seg_font(exp_flags[3:0]), seg6);
            // minus sign is segment g alone
            check_value("seg7", exp_flags[3] ? 8'hbf : 8'hff, seg7);
        end
    endtask

    task automatic test_random();
        sw[15] = 1'b1;
        repeat (lfsr_steps) begin
            @(negedge btn);
            rnd_model = lfsr_next(rnd_model);
        end
        sw[15] = 1'b0;
        check_value("seg4", seg_font(rnd_model[3:0]), seg4);
        check_value("seg5", seg_font(rnd_model[7:4]), seg5);
        check_value("ledr[15:9]", 7'd0, ledr[15:9]);
        repeat (10) @(negedge btn);
        check_value("seg4 held", seg_font(rnd_model[3:0]), seg4);
        check_value("seg5 held", seg_font(rnd_model[7:4]), seg5);
    endtask

    task automatic test_keyboard();
        send_ps2(8'h1c, 1'b0);
        send_ps2(8'h32, 1'b0);
        send_ps2(8'h45, 1'b0);
        wait_ready(10);
        show_head(8'h1c);
        pop_key();
        show_head(8'h32);
        pop_key();
        show_head(8'h45);
        pop_key();
        check_value("ledr[7]", 1'b0, ledr[7]);
        show_head(8'h00);
    endtask

    task automatic test_parity_error();
        send_ps2(8'h1c, 1'b1);
        check_value("ledr[7]", 1'b0, ledr[7]);
        check_value("ledr[8]", 1'b0, ledr[8]);
        show_head(8'h00);
    endtask

    task automatic test_overflow();
        logic [7:0] codes [9] = '{8'h16, 8'h1e, 8'h26, 8'h25, 8'h2e,
                                  8'h36, 8'h3d, 8'h3e, 8'h46};
        foreach (codes[i]) begin
            send_ps2(codes[i], 1'b0);
        end
        wait_ready(10);
        check_value("ledr[8]", 1'b1, ledr[8]);
        for (int i = 0; i < 8; i++) begin
            check_value("ledr[7]", 1'b1, ledr[7]);
            show_head(codes[i]);
            pop_key();
        end
        check_value("ledr[7]", 1'b0, ledr[7]);
    endtask

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'ha804_c62f;
        btn = 1'b0;
        rst_n = 1'b0;
        sw = 16'd0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        rnd_model = 8'd1;
        repeat (10) @(negedge btn);
        rst_n = 1'b1;
        @(negedge btn);
        test_reset_state();
        test_alu();
        test_random();
        test_keyboard();
        test_parity_error();
        test_overflow();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
board_pkg.sv
alu.sv
lfsr_random.sv
ps2_receiver.sv
scancode_queue.sv
hex_to_seg.sv
board_top.sv
tb_board_top.sv

// ==== Bender.yml ====
package:
  name: board_lab

export_include_dirs:
  - .

sources:
  - files:
      - board_pkg.sv
      - alu.sv
      - lfsr_random.sv
      - ps2_receiver.sv
      - scancode_queue.sv
      - hex_to_seg.sv
      - board_top.sv
  - target: test
    files:
      - tb_board_top.sv
